// ==== rtl/rf_types_pkg.sv ====
//////////////////////////////
// Geometry and data types of the register file
// Entry count, word and byte-lane widths, and the binary address and
// one-hot select word types shared by every RTL block
//////////////////////////////

package rf_types_pkg;

   // Array geometry
   localparam int DEPTH  = 32;
   localparam int WORD_W = 16;
   localparam int BYTE_W = 8;

   // Binary entry address
   typedef logic [$clog2(DEPTH)-1:0] addr_t;

   // Data word and one byte lane of it
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [BYTE_W-1:0] byte_t;

   // One-hot select, one bit per entry, entry 31 in the top bit
   typedef logic [DEPTH-1:0] sel_t;

endpackage

// ==== rtl/rf_port_pkg.sv ====
//////////////////////////////
// Port-level definitions of the register file
// Read-port count, per-read-port mask and the error and conflict
// status word with its bit positions
//////////////////////////////

package rf_port_pkg;

   localparam int N_RD = 3;

   // Bit 0 is port A, bit 1 port B, bit 2 port C
   typedef logic [N_RD-1:0] rd_mask_t;

   typedef logic [9:0] status_t;

   // Address errors
   localparam int ST_RA_ERR      = 0;
   localparam int ST_RB_ERR      = 1;
   localparam int ST_RC_ERR      = 2;
   localparam int ST_WO_ERR      = 3;
   localparam int ST_WIX_ERR     = 4;
   localparam int ST_WIY_ERR     = 5;
   // Conflicts
   localparam int ST_WR_CONFLICT = 6;
   localparam int ST_A_CONFLICT  = 7;
   localparam int ST_B_CONFLICT  = 8;
   localparam int ST_C_CONFLICT  = 9;

endpackage

// ==== rtl/onehot_addr_decode.sv ====
//////////////////////////////
// Dual-rail one-hot address decoder
// Checks a select word against its complement word and encodes the
// single set bit to a binary address; purely combinational
//////////////////////////////

module onehot_addr_decode #(
   parameter int SEL_W      = 32,
   parameter bit ALLOW_IDLE = 1'b0
) (
   input  rf_types_pkg::sel_t  sel,
   input  rf_types_pkg::sel_t  sel_b,
   output rf_types_pkg::addr_t addr,
   output logic                hit,
   output logic                err
);

   logic                pair_ok;
   logic                one_hot;
   logic                idle;
   rf_types_pkg::addr_t enc;

   // Both rails must be exact inverses over the used width
   assign pair_ok = (sel_b[SEL_W-1:0] == ~sel[SEL_W-1:0]);

   // Non-zero with no second bit set
   assign one_hot = (sel[SEL_W-1:0] != '0) &&
                    ((sel & (sel - rf_types_pkg::sel_t'(1))) == '0);

   assign idle = (sel[SEL_W-1:0] == '0) && (sel_b[SEL_W-1:0] == '1);

   // OR encoder that is exact only when a single bit is set
   always_comb begin
      enc = '0;
      for (int i = 0; i < SEL_W; i++) begin
         if (sel[i]) begin
            enc = enc | rf_types_pkg::addr_t'(i);
         end
      end
   end

   assign hit  = pair_ok && one_hot;
   assign addr = hit ? enc : '0;

   // Idle is silent only on ports that may idle
   assign err = !hit && !(ALLOW_IDLE && idle);

endmodule

// ==== rtl/rf_hazard_ctrl.sv ====
//////////////////////////////
// Hazard and error control
// Turns decoded addresses, hits and errors into write enables and a
// read zero mask, and registers the ten status flags each cycle
//////////////////////////////

module rf_hazard_ctrl (
   input  logic                   clk,
   input  logic                   reset,
   input  rf_types_pkg::addr_t    ra_addr,
   input  rf_types_pkg::addr_t    rb_addr,
   input  rf_types_pkg::addr_t    rc_addr,
   input  rf_types_pkg::addr_t    wo_addr,
   input  rf_types_pkg::addr_t    wix_addr,
   input  rf_types_pkg::addr_t    wiy_addr,
   input  logic                   ra_err,
   input  logic                   rb_err,
   input  logic                   rc_err,
   input  logic                   wo_hit,
   input  logic                   wix_hit,
   input  logic                   wiy_hit,
   input  logic                   wo_err,
   input  logic                   wix_err,
   input  logic                   wiy_err,
   output logic                   wo_we,
   output logic                   wix_we,
   output logic                   wiy_we,
   output rf_port_pkg::rd_mask_t  rd_zero,
   output rf_port_pkg::status_t   status
);

   logic                 o_ix_clash;
   logic                 o_iy_clash;
   logic                 wr_conflict;
   logic                 ra_conf;
   logic                 rb_conf;
   logic                 rc_conf;
   rf_port_pkg::status_t status_d;

   // Full-word port against either byte port on the same entry
   // IX and IY may share an entry since their lanes are disjoint
   assign o_ix_clash  = wo_hit && wix_hit && (wo_addr == wix_addr);
   assign o_iy_clash  = wo_hit && wiy_hit && (wo_addr == wiy_addr);
   assign wr_conflict = o_ix_clash || o_iy_clash;

   // A conflict blocks every write of the cycle
   // A hit from the decoder already excludes an address error
   assign wo_we  = wo_hit && !wr_conflict;
   assign wix_we = wix_hit && !wr_conflict;
   assign wiy_we = wiy_hit && !wr_conflict;

   // Read against any write that actually goes ahead this edge
   assign ra_conf = !ra_err && ((wo_we && (ra_addr == wo_addr)) ||
                                (wix_we && (ra_addr == wix_addr)) ||
                                (wiy_we && (ra_addr == wiy_addr)));
   assign rb_conf = !rb_err && ((wo_we && (rb_addr == wo_addr)) ||
                                (wix_we && (rb_addr == wix_addr)) ||
                                (wiy_we && (rb_addr == wiy_addr)));
   assign rc_conf = !rc_err && ((wo_we && (rc_addr == wo_addr)) ||
                                (wix_we && (rc_addr == wix_addr)) ||
                                (wiy_we && (rc_addr == wiy_addr)));

   assign rd_zero = {rc_err || rc_conf, rb_err || rb_conf, ra_err || ra_conf};

   always_comb begin
      status_d = '0;
      status_d[rf_port_pkg::ST_RA_ERR]      = ra_err;
      status_d[rf_port_pkg::ST_RB_ERR]      = rb_err;
      status_d[rf_port_pkg::ST_RC_ERR]      = rc_err;
      status_d[rf_port_pkg::ST_WO_ERR]      = wo_err;
      status_d[rf_port_pkg::ST_WIX_ERR]     = wix_err;
      status_d[rf_port_pkg::ST_WIY_ERR]     = wiy_err;
      status_d[rf_port_pkg::ST_WR_CONFLICT] = wr_conflict;
      status_d[rf_port_pkg::ST_A_CONFLICT]  = ra_conf;
      status_d[rf_port_pkg::ST_B_CONFLICT]  = rb_conf;
      status_d[rf_port_pkg::ST_C_CONFLICT]  = rc_conf;
   end

   // Flags hold for one cycle, aligned with the read outputs
   always_ff @(posedge clk) begin
      if (reset) begin
         status <= '0;
      end else begin
         status <= status_d;
      end
   end

endmodule

// ==== rtl/rf_storage.sv ====
//////////////////////////////
// Register file array
// One full-word write port, two byte-lane write ports on d1 and three
// registered read ports returning the contents from before the edge
//////////////////////////////

module rf_storage #(
   parameter int DEPTH = 32
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wo_we,
   input  logic                  wix_we,
   input  logic                  wiy_we,
   input  rf_types_pkg::addr_t   wo_addr,
   input  rf_types_pkg::addr_t   wix_addr,
   input  rf_types_pkg::addr_t   wiy_addr,
   input  rf_types_pkg::word_t   d0,
   input  rf_types_pkg::word_t   d1,
   input  rf_types_pkg::addr_t   ra_addr,
   input  rf_types_pkg::addr_t   rb_addr,
   input  rf_types_pkg::addr_t   rc_addr,
   input  rf_port_pkg::rd_mask_t rd_zero,
   output rf_types_pkg::word_t   a,
   output rf_types_pkg::word_t   b,
   output rf_types_pkg::word_t   c
);

   localparam int BW = rf_types_pkg::BYTE_W;
   localparam int WW = rf_types_pkg::WORD_W;

   rf_types_pkg::word_t mem [DEPTH];
   rf_types_pkg::byte_t d1_lo;
   rf_types_pkg::byte_t d1_hi;

   assign d1_lo = d1[BW-1:0];
   assign d1_hi = d1[WW-1:BW];

   // Control guarantees O never shares an entry with IX or IY here
   always_ff @(posedge clk) begin
      if (wo_we) begin
         mem[wo_addr] <= d0;
      end
      if (wix_we) begin
         mem[wix_addr][BW-1:0] <= d1_lo;
      end
      if (wiy_we) begin
         mem[wiy_addr][WW-1:BW] <= d1_hi;
      end
   end

   // Reads sample the array before this edge's writes land
   always_ff @(posedge clk) begin
      if (reset) begin
         a <= '0;
         b <= '0;
         c <= '0;
      end else begin
         a <= rd_zero[0] ? '0 : mem[ra_addr];
         b <= rd_zero[1] ? '0 : mem[rb_addr];
         c <= rd_zero[2] ? '0 : mem[rc_addr];
      end
   end

endmodule

// ==== rtl/rf3r2w_top.sv ====
//////////////////////////////
// 32 x 16 register file, three read ports and three write ports
// Every port is addressed by a dual-rail one-hot select pair; results
// and status appear one cycle after the inputs are sampled
//////////////////////////////

module rf3r2w_top #(
   parameter int DEPTH = rf_types_pkg::DEPTH
) (
   input  logic                 clk,
   input  logic                 reset,
   input  rf_types_pkg::sel_t   ra_sel,
   input  rf_types_pkg::sel_t   ra_sel_b,
   input  rf_types_pkg::sel_t   rb_sel,
   input  rf_types_pkg::sel_t   rb_sel_b,
   input  rf_types_pkg::sel_t   rc_sel,
   input  rf_types_pkg::sel_t   rc_sel_b,
   input  rf_types_pkg::sel_t   wo_sel,
   input  rf_types_pkg::sel_t   wo_sel_b,
   input  rf_types_pkg::sel_t   wix_sel,
   input  rf_types_pkg::sel_t   wix_sel_b,
   input  rf_types_pkg::sel_t   wiy_sel,
   input  rf_types_pkg::sel_t   wiy_sel_b,
   input  rf_types_pkg::word_t  d0,
   input  rf_types_pkg::word_t  d1,
   output rf_types_pkg::word_t  a,
   output rf_types_pkg::word_t  b,
   output rf_types_pkg::word_t  c,
   output rf_port_pkg::status_t status
);

   rf_types_pkg::addr_t   ra_addr, rb_addr, rc_addr;
   rf_types_pkg::addr_t   wo_addr, wix_addr, wiy_addr;
   logic                  ra_err, rb_err, rc_err;
   logic                  wo_hit, wix_hit, wiy_hit;
   logic                  wo_err, wix_err, wiy_err;
   logic                  wo_we, wix_we, wiy_we;
   rf_port_pkg::rd_mask_t rd_zero;

   // Read ports have no idle code, so only their error is used
   onehot_addr_decode #(.SEL_W(DEPTH), .ALLOW_IDLE(1'b0)) u_dec_ra (
      .sel(ra_sel), .sel_b(ra_sel_b), .addr(ra_addr), .hit(), .err(ra_err)
   );
   onehot_addr_decode #(.SEL_W(DEPTH), .ALLOW_IDLE(1'b0)) u_dec_rb (
      .sel(rb_sel), .sel_b(rb_sel_b), .addr(rb_addr), .hit(), .err(rb_err)
   );
   onehot_addr_decode #(.SEL_W(DEPTH), .ALLOW_IDLE(1'b0)) u_dec_rc (
      .sel(rc_sel), .sel_b(rc_sel_b), .addr(rc_addr), .hit(), .err(rc_err)
   );

   onehot_addr_decode #(.SEL_W(DEPTH), .ALLOW_IDLE(1'b1)) u_dec_wo (
      .sel(wo_sel), .sel_b(wo_sel_b), .addr(wo_addr), .hit(wo_hit), .err(wo_err)
   );
   onehot_addr_decode #(.SEL_W(DEPTH), .ALLOW_IDLE(1'b1)) u_dec_wix (
      .sel(wix_sel), .sel_b(wix_sel_b), .addr(wix_addr), .hit(wix_hit), .err(wix_err)
   );
   onehot_addr_decode #(.SEL_W(DEPTH), .ALLOW_IDLE(1'b1)) u_dec_wiy (
      .sel(wiy_sel), .sel_b(wiy_sel_b), .addr(wiy_addr), .hit(wiy_hit), .err(wiy_err)
   );

   rf_hazard_ctrl u_ctrl (
      .clk      (clk),
      .reset    (reset),
      .ra_addr  (ra_addr),
      .rb_addr  (rb_addr),
      .rc_addr  (rc_addr),
      .wo_addr  (wo_addr),
      .wix_addr (wix_addr),
      .wiy_addr (wiy_addr),
      .ra_err   (ra_err),
      .rb_err   (rb_err),
      .rc_err   (rc_err),
      .wo_hit   (wo_hit),
      .wix_hit  (wix_hit),
      .wiy_hit  (wiy_hit),
      .wo_err   (wo_err),
      .wix_err  (wix_err),
      .wiy_err  (wiy_err),
      .wo_we    (wo_we),
      .wix_we   (wix_we),
      .wiy_we   (wiy_we),
      .rd_zero  (rd_zero),
      .status   (status)
   );

   rf_storage #(.DEPTH(DEPTH)) u_storage (
      .clk      (clk),
      .reset    (reset),
      .wo_we    (wo_we),
      .wix_we   (wix_we),
      .wiy_we   (wiy_we),
      .wo_addr  (wo_addr),
      .wix_addr (wix_addr),
      .wiy_addr (wiy_addr),
      .d0       (d0),
      .d1       (d1),
      .ra_addr  (ra_addr),
      .rb_addr  (rb_addr),
      .rc_addr  (rc_addr),
      .rd_zero  (rd_zero),
      .a        (a),
      .b        (b),
      .c        (c)
   );

endmodule

// ==== dv/tb_clk_gen.sv ====
//////////////////////////////
// Testbench clock and reset source
// 4 ns clock, reset held high for the first 16 rising edges
//////////////////////////////

module tb_clk_gen (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RST_CYCLES = 16;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Released shortly after an edge, like the rest of the stimulus
   initial begin
      reset = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

// ==== dv/rf3r2w_asserts.sv ====
//////////////////////////////
// Invariant checks on the hazard control block
// Bound into rf_hazard_ctrl by the testbench
//////////////////////////////

module rf3r2w_asserts (
   input logic                 clk,
   input logic                 reset,
   input logic                 wo_we,
   input logic                 wix_we,
   input logic                 wiy_we,
   input rf_types_pkg::addr_t  wo_addr,
   input rf_types_pkg::addr_t  wix_addr,
   input rf_types_pkg::addr_t  wiy_addr,
   input logic                 wo_err,
   input logic                 wix_err,
   input logic                 wiy_err,
   input rf_port_pkg::status_t status
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;

   // IX and IY may share an entry, O may share with neither
   no_write_clash: assert property (@(posedge clk) disable iff (reset)
      !(wo_we && wix_we && (wo_addr == wix_addr)) &&
      !(wo_we && wiy_we && (wo_addr == wiy_addr)))
   else begin
      $error("Full-word write enabled on the same entry as a byte write");
      fail_cnt++;
   end

   no_write_on_err: assert property (@(posedge clk) disable iff (reset)
      !(wo_we && wo_err) && !(wix_we && wix_err) && !(wiy_we && wiy_err))
   else begin
      $error("Write enabled on a port with an address error");
      fail_cnt++;
   end

   status_clear_after_reset: assert property (@(posedge clk) reset |=> (status == '0))
   else begin
      $error("Status not clear in the cycle after reset");
      fail_cnt++;
   end

endmodule

// ==== dv/rf3r2w_tb.sv ====
//////////////////////////////
// Testbench for the 32 x 16 register file
// Drives all six select pairs, predicts a, b, c and status from a
// shadow array and checks them one cycle after each operation
//////////////////////////////

module rf3r2w_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DEPTH   = rf_types_pkg::DEPTH;
   localparam int N_CYC   = 2 * DEPTH + 4 * 3 + 2 * 2 + 6 + 40 + 8;
   localparam int TIMEOUT = (16 + N_CYC + 40) * 4;
   // Kinds of select pair
   localparam logic [1:0] K_VALID = 2'd0;
   localparam logic [1:0] K_IDLE  = 2'd1;
   localparam logic [1:0] K_TWO   = 2'd2;
   localparam logic [1:0] K_FLIP  = 2'd3;

   logic                 clk;
   logic                 reset;
   // Port order 0..5 is A, B, C, O, IX, IY
   rf_types_pkg::sel_t   sel [6];
   rf_types_pkg::sel_t   sel_b [6];
   rf_types_pkg::word_t  d0;
   rf_types_pkg::word_t  d1;
   rf_types_pkg::word_t  a;
   rf_types_pkg::word_t  b;
   rf_types_pkg::word_t  c;
   rf_port_pkg::status_t status;
   rf_types_pkg::word_t  shadow [DEPTH];
   logic [1:0]           kind [6];
   int                   addr [6];
   int                   seed = 53;
   int                   err_cnt = 0;

   tb_clk_gen u_clk_gen (.clk(clk), .reset(reset));

   rf3r2w_top i_dut (
      .clk(clk), .reset(reset),
      .ra_sel(sel[0]), .ra_sel_b(sel_b[0]), .rb_sel(sel[1]), .rb_sel_b(sel_b[1]),
      .rc_sel(sel[2]), .rc_sel_b(sel_b[2]), .wo_sel(sel[3]), .wo_sel_b(sel_b[3]),
      .wix_sel(sel[4]), .wix_sel_b(sel_b[4]), .wiy_sel(sel[5]), .wiy_sel_b(sel_b[5]),
      .d0(d0), .d1(d1), .a(a), .b(b), .c(c), .status(status)
   );

   bind rf_hazard_ctrl rf3r2w_asserts u_asserts (.*);

   function automatic int rand_addr();
      return $unsigned($random(seed)) % DEPTH;
   endfunction

   task automatic set_port(int p, logic [1:0] k, int ad);
      kind[p] = k;
      addr[p] = ad;
   endtask

   task automatic randomize_ports(int first, int last);
      for (int p = first; p <= last; p++) begin
         set_port(p, K_VALID, rand_addr());
      end
   endtask

   task automatic idle_writes();
      for (int p = 3; p < 6; p++) begin
         set_port(p, K_IDLE, 0);
      end
   endtask

   task automatic compare_value(string name, logic [15:0] exp, logic [15:0] act);
      assert (act === exp) else begin
         $display("Mismatch %s: expected %h actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   // Drive the pairs and predict the outputs, then check them after the edge
   task automatic step();
      logic                 hit [6];
      logic                 err [6];
      logic                 we [6];
      logic                 wr_conf;
      logic                 conf;
      rf_port_pkg::status_t exp_st;
      rf_types_pkg::word_t  exp_rd [3];
      exp_st = '0;
      for (int p = 0; p < 6; p++) begin
         sel[p] = '0;
         if (kind[p] != K_IDLE) begin
            sel[p][addr[p]] = 1'b1;
         end
         if (kind[p] == K_TWO) begin
            sel[p][(addr[p] + 1) % DEPTH] = 1'b1;
         end
         sel_b[p] = ~sel[p];
         if (kind[p] == K_FLIP) begin
            sel_b[p][(addr[p] + 5) % DEPTH] = sel[p][(addr[p] + 5) % DEPTH];
         end
         hit[p] = (kind[p] == K_VALID);
         err[p] = !hit[p] && !(p >= 3 && kind[p] == K_IDLE);
      end
      wr_conf = hit[3] && ((hit[4] && addr[3] == addr[4]) ||
                           (hit[5] && addr[3] == addr[5]));
      exp_st[rf_port_pkg::ST_WR_CONFLICT] = wr_conf;
      for (int p = 3; p < 6; p++) begin
         we[p] = hit[p] && !wr_conf;
         exp_st[rf_port_pkg::ST_WO_ERR + p - 3] = err[p];
      end
      for (int r = 0; r < 3; r++) begin
         conf = 1'b0;
         for (int p = 3; p < 6; p++) begin
            conf = conf || (we[p] && addr[r] == addr[p]);
         end
         conf = conf && !err[r];
         exp_st[rf_port_pkg::ST_RA_ERR + r] = err[r];
         exp_st[rf_port_pkg::ST_A_CONFLICT + r] = conf;
         exp_rd[r] = (err[r] || conf) ? '0 : shadow[addr[r]];
      end
      @(posedge clk);
      #1;
      compare_value("a", exp_rd[0], a);
      compare_value("b", exp_rd[1], b);
      compare_value("c", exp_rd[2], c);
      compare_value("status", exp_st, status);
      if (we[3]) begin
         shadow[addr[3]] = d0;
      end
      if (we[4]) begin
         shadow[addr[4]][7:0] = d1[7:0];
      end
      if (we[5]) begin
         shadow[addr[5]][15:8] = d1[15:8];
      end
   endtask

   initial begin
      int x;
      for (int p = 0; p < 6; p++) begin
         sel[p] = '0;
         sel_b[p] = '1;
      end
      d0 = '0;
      d1 = '0;
      @(negedge reset);
      // Fill every entry through O while the reads run ahead of the write pointer
      for (int i = 0; i < DEPTH; i++) begin
         for (int r = 0; r < 3; r++) begin
            set_port(r, K_VALID, (i + r + 1) % DEPTH);
         end
         idle_writes();
         set_port(3, K_VALID, i);
         d0 = $random(seed);
         step();
      end
      for (int i = 0; i < DEPTH; i++) begin
         set_port(0, K_VALID, i);
         set_port(1, K_VALID, (i + 11) % DEPTH);
         set_port(2, K_VALID, (i + 22) % DEPTH);
         idle_writes();
         step();
      end
      // Byte lanes on a shared entry, then on separate entries
      for (int i = 0; i < 4; i++) begin
         x = rand_addr();
         randomize_ports(0, 2);
         idle_writes();
         set_port(4, K_VALID, x);
         set_port(5, K_VALID, x);
         d1 = $random(seed);
         step();
         set_port(5, K_VALID, (x + 1 + i) % DEPTH);
         d1 = $random(seed);
         step();
         set_port(0, K_VALID, x);
         set_port(1, K_VALID, addr[5]);
         idle_writes();
         step();
      end
      // O against IX, then O against IY, on one entry
      for (int p = 4; p < 6; p++) begin
         randomize_ports(0, 5);
         set_port(p, K_VALID, addr[3]);
         d0 = $random(seed);
         d1 = $random(seed);
         step();
         set_port(0, K_VALID, addr[3]);
         set_port(1, K_VALID, addr[4]);
         set_port(2, K_VALID, addr[5]);
         idle_writes();
         step();
      end
      // Reads aimed at the entries being written
      for (int i = 0; i < 6; i++) begin
         randomize_ports(1, 5);
         set_port(0, K_VALID, addr[3 + i % 3]);
         set_port(2, K_VALID, addr[3 + (i + 1) % 3]);
         d0 = $random(seed);
         d1 = $random(seed);
         step();
      end
      // Valid, idle and malformed pairs mixed on every port
      for (int i = 0; i < 40; i++) begin
         for (int p = 0; p < 6; p++) begin
            x = $random(seed);
            set_port(p, 2'(x), rand_addr());
         end
         d0 = $random(seed);
         d1 = $random(seed);
         step();
      end
      for (int i = 0; i < 8; i++) begin
         randomize_ports(0, 2);
         idle_writes();
         d0 = $random(seed);
         d1 = $random(seed);
         step();
      end
      $display("Done: %0d mismatches, %0d assertion failures",
               err_cnt, i_dut.u_ctrl.u_asserts.fail_cnt);
      if (err_cnt == 0 && i_dut.u_ctrl.u_asserts.fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // Watchdog sized from the stimulus length
   initial begin
      #(TIMEOUT);
      $display("Timeout: stimulus did not complete within %0d ns", TIMEOUT);
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== rf3r2w.f ====
rtl/rf_types_pkg.sv
rtl/rf_port_pkg.sv
rtl/onehot_addr_decode.sv
rtl/rf_hazard_ctrl.sv
rtl/rf_storage.sv
rtl/rf3r2w_top.sv
dv/tb_clk_gen.sv
dv/rf3r2w_asserts.sv
dv/rf3r2w_tb.sv
